//--- Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_geometry_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/dcache_tag_store.sv
  - logic/dcache_data_ram.sv
  - logic/dcache_miss_ctrl.sv
  - logic/dcache.sv
  - target: test
    files:
      - testbench/dcache_properties.sv
      - testbench/dcache_tb.sv

//--- dcache.f
logic/dcache_geometry_pkg.sv
logic/mem_bus_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_ram.sv
logic/dcache_miss_ctrl.sv
logic/dcache.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

//--- logic/dcache.sv
`timescale 1ns/10ps

module dcache (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 req_valid,
    input  mem_bus_pkg::addr_t   req_addr,
    input  mem_bus_pkg::strobe_t req_strobe,
    input  mem_bus_pkg::word_t   req_wdata,
    input  logic                 mem_ready,
    input  logic                 mem_last,
    input  mem_bus_pkg::word_t   mem_rdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output mem_bus_pkg::word_t   rdata,
    output logic                 mem_valid,
    output logic                 mem_write,
    output mem_bus_pkg::addr_t   mem_addr,
    output mem_bus_pkg::word_t   mem_wdata
);

    logic en;
    logic accept;

    // stage 2 request
    logic s2_valid;
    logic s2_hit;
    mem_bus_pkg::addr_t s2_addr;
    mem_bus_pkg::strobe_t s2_strobe;
    mem_bus_pkg::word_t s2_wdata;
    dcache_geometry_pkg::way_t s2_way;
    dcache_geometry_pkg::index_t s2_index;
    dcache_geometry_pkg::tag_t s2_tag;
    dcache_geometry_pkg::offset_t s2_offset;

    mem_bus_pkg::addr_t lookup_addr;
    logic hit;
    dcache_geometry_pkg::way_t hit_way;
    dcache_geometry_pkg::way_t victim_way;
    logic victim_dirty;
    dcache_geometry_pkg::tag_t victim_tag;

    logic miss_start;
    logic busy;
    logic done;
    logic fill;

    logic a_en;
    dcache_geometry_pkg::ram_addr_t a_addr;
    mem_bus_pkg::word_t a_rdata;
    logic b_en;
    dcache_geometry_pkg::ram_addr_t b_addr;
    mem_bus_pkg::strobe_t b_strobe;
    mem_bus_pkg::word_t b_wdata;
    mem_bus_pkg::word_t b_rdata;

    logic data_ok_q;

    assign accept = en & req_valid;

    // while stalled the tag store looks at the parked miss
    assign lookup_addr = en ? req_addr : s2_addr;

    always_ff @(posedge clk) begin
        if (resetn) begin
            en <= 1'b1;
        end else if (accept && !hit) begin
            en <= 1'b0;
        end else if (done) begin
            en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            s2_valid <= 1'b0;
            s2_hit <= 1'b0;
        end else if (en) begin
            s2_valid <= req_valid;
            s2_hit <= hit;
        end else if (done) begin
            s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            s2_addr <= req_addr;
            s2_strobe <= req_strobe;
            s2_wdata <= req_wdata;
            s2_way <= hit_way;
        end else if (miss_start) begin
            // replay goes to the way being refilled
            s2_way <= victim_way;
        end
    end

    assign s2_index = dcache_geometry_pkg::index_t'(s2_addr >> dcache_geometry_pkg::INDEX_LSB);
    assign s2_tag = dcache_geometry_pkg::tag_t'(s2_addr >> dcache_geometry_pkg::TAG_LSB);
    assign s2_offset = dcache_geometry_pkg::offset_t'(s2_addr >> dcache_geometry_pkg::OFFSET_LSB);

    assign miss_start = s2_valid & ~s2_hit & ~busy;

    dcache_tag_store tag_store_inst (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_addr  (lookup_addr),
        .update_hit   (s2_valid & s2_hit),
        .update_way   (s2_way),
        .update_index (s2_index),
        .update_write (|s2_strobe),
        .fill         (fill),
        .fill_index   (s2_index),
        .fill_tag     (s2_tag),
        .fill_dirty   (|s2_strobe),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // port a: stage 2 hit or the replay after a refill
    assign a_en = (s2_valid & s2_hit) | done;
    assign a_addr = {s2_way, s2_index, s2_offset};

    dcache_data_ram data_ram_inst (
        .clk      (clk),
        .a_en     (a_en),
        .a_addr   (a_addr),
        .a_strobe (s2_strobe),
        .a_wdata  (s2_wdata),
        .b_en     (b_en),
        .b_addr   (b_addr),
        .b_strobe (b_strobe),
        .b_wdata  (b_wdata),
        .a_rdata  (a_rdata),
        .b_rdata  (b_rdata)
    );

    dcache_miss_ctrl miss_ctrl_inst (
        .clk          (clk),
        .resetn       (resetn),
        .start        (miss_start),
        .req_addr     (s2_addr),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .ram_rdata    (b_rdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .busy         (busy),
        .done         (done),
        .ram_en       (b_en),
        .ram_addr     (b_addr),
        .ram_strobe   (b_strobe),
        .ram_wdata    (b_wdata),
        .fill         (fill),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    // response lines up with the ram read latency
    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= a_en;
        end
    end

    assign addr_ok = en;
    assign data_ok = data_ok_q;
    assign rdata = a_rdata;

endmodule

//--- logic/dcache_data_ram.sv
`timescale 1ns/10ps

module dcache_data_ram (
    input  logic                           clk,
    input  logic                           a_en,
    input  dcache_geometry_pkg::ram_addr_t a_addr,
    input  mem_bus_pkg::strobe_t           a_strobe,
    input  mem_bus_pkg::word_t             a_wdata,
    input  logic                           b_en,
    input  dcache_geometry_pkg::ram_addr_t b_addr,
    input  mem_bus_pkg::strobe_t           b_strobe,
    input  mem_bus_pkg::word_t             b_wdata,
    output mem_bus_pkg::word_t             a_rdata,
    output mem_bus_pkg::word_t             b_rdata
);

    localparam int DEPTH = dcache_geometry_pkg::WAYS * dcache_geometry_pkg::SETS
                         * dcache_geometry_pkg::LINE_WORDS;
    localparam int LANES = $bits(mem_bus_pkg::strobe_t);

    mem_bus_pkg::word_t mem [DEPTH];

    // read-first on both ports, port b wins a same-word write
    always_ff @(posedge clk) begin
        if (a_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (a_strobe[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
            a_rdata <= mem[a_addr];
        end
        if (b_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (b_strobe[i]) begin
                    mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
                end
            end
            b_rdata <= mem[b_addr];
        end
    end

endmodule

//--- logic/dcache_geometry_pkg.sv
package dcache_geometry_pkg;

    // 2 ways x 64 sets x 16 words of 32 bits
    localparam int WAYS = 2;
    localparam int SETS = 64;
    localparam int LINE_WORDS = 16;

    // byte address split: tag | index | offset | byte
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB = OFFSET_LSB + $clog2(LINE_WORDS);
    localparam int TAG_LSB = INDEX_LSB + $clog2(SETS);

    typedef logic [$clog2(SETS)-1:0] index_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] offset_t;
    typedef logic [31-TAG_LSB:0] tag_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;

    // data ram word address {way, index, offset}
    typedef logic [$bits(way_t)+$bits(index_t)+$bits(offset_t)-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        REPLAY
    } miss_state_t;

endpackage

//--- logic/dcache_miss_ctrl.sv
`timescale 1ns/10ps

module dcache_miss_ctrl (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           start,
    input  mem_bus_pkg::addr_t             req_addr,
    input  dcache_geometry_pkg::way_t      victim_way,
    input  logic                           victim_dirty,
    input  dcache_geometry_pkg::tag_t      victim_tag,
    input  mem_bus_pkg::word_t             ram_rdata,
    input  logic                           mem_ready,
    input  logic                           mem_last,
    input  mem_bus_pkg::word_t             mem_rdata,
    output logic                           busy,
    output logic                           done,
    output logic                           ram_en,
    output dcache_geometry_pkg::ram_addr_t ram_addr,
    output mem_bus_pkg::strobe_t           ram_strobe,
    output mem_bus_pkg::word_t             ram_wdata,
    output logic                           fill,
    output logic                           mem_valid,
    output logic                           mem_write,
    output mem_bus_pkg::addr_t             mem_addr,
    output mem_bus_pkg::word_t             mem_wdata
);

    dcache_geometry_pkg::miss_state_t state;

    // words read out of the ram so far, 0 to 16
    logic [$clog2(dcache_geometry_pkg::LINE_WORDS):0] rd_cnt;
    logic rd_valid;
    logic rd_issue;
    dcache_geometry_pkg::offset_t rd_slot;
    dcache_geometry_pkg::offset_t beat;
    logic beat_done;

    dcache_geometry_pkg::way_t line_way;
    dcache_geometry_pkg::tag_t wb_tag;
    dcache_geometry_pkg::index_t line_index;
    dcache_geometry_pkg::tag_t line_tag;
    dcache_geometry_pkg::offset_t ram_offset;
    mem_bus_pkg::word_t line_buf [dcache_geometry_pkg::LINE_WORDS];

    // request stays parked in stage 2 for the whole miss
    assign line_index = dcache_geometry_pkg::index_t'(req_addr >> dcache_geometry_pkg::INDEX_LSB);
    assign line_tag = dcache_geometry_pkg::tag_t'(req_addr >> dcache_geometry_pkg::TAG_LSB);

    assign beat_done = mem_valid & mem_ready;
    assign rd_issue = (state == dcache_geometry_pkg::WRITEBACK)
                   && (rd_cnt < mem_bus_pkg::BURST_LEN);
    assign rd_slot = dcache_geometry_pkg::offset_t'(rd_cnt - 1'b1);

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= dcache_geometry_pkg::IDLE;
            rd_cnt <= '0;
            rd_valid <= 1'b0;
            beat <= '0;
        end else begin
            rd_valid <= rd_issue;
            case (state)
                dcache_geometry_pkg::IDLE: begin
                    if (start) begin
                        state <= victim_dirty ? dcache_geometry_pkg::WRITEBACK
                                              : dcache_geometry_pkg::REFILL;
                        rd_cnt <= '0;
                        beat <= '0;
                    end
                end
                dcache_geometry_pkg::WRITEBACK: begin
                    if (rd_issue) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    // beat wraps to zero for the refill
                    if (beat_done) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_geometry_pkg::REFILL;
                        end
                    end
                end
                dcache_geometry_pkg::REFILL: begin
                    if (beat_done) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_geometry_pkg::REPLAY;
                        end
                    end
                end
                default: begin
                    state <= dcache_geometry_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_geometry_pkg::IDLE && start) begin
            line_way <= victim_way;
            wb_tag <= victim_tag;
        end
        if (rd_valid) begin
            line_buf[rd_slot] <= ram_rdata;
        end
    end

    assign busy = (state != dcache_geometry_pkg::IDLE);
    assign done = (state == dcache_geometry_pkg::REPLAY);
    assign fill = (state == dcache_geometry_pkg::REFILL) && beat_done && mem_last;

    // ram side: line reads ahead of the beats, then refill writes
    assign ram_offset = (state == dcache_geometry_pkg::WRITEBACK)
                      ? dcache_geometry_pkg::offset_t'(rd_cnt) : beat;
    assign ram_en = rd_issue || ((state == dcache_geometry_pkg::REFILL) && beat_done);
    assign ram_addr = {line_way, line_index, ram_offset};
    assign ram_strobe = (state == dcache_geometry_pkg::REFILL) ? '1 : '0;
    assign ram_wdata = mem_rdata;

    // first beat waits until word 0 sits in the buffer
    assign mem_valid = ((state == dcache_geometry_pkg::WRITEBACK) && (rd_cnt > 1))
                    || (state == dcache_geometry_pkg::REFILL);
    assign mem_write = (state == dcache_geometry_pkg::WRITEBACK);
    assign mem_addr = {(mem_write ? wb_tag : line_tag), line_index,
                       {dcache_geometry_pkg::INDEX_LSB{1'b0}}};
    assign mem_wdata = line_buf[beat];

endmodule

//--- logic/dcache_tag_store.sv
`timescale 1ns/10ps

module dcache_tag_store (
    input  logic                       clk,
    input  logic                       resetn,
    input  mem_bus_pkg::addr_t         lookup_addr,
    input  logic                       update_hit,
    input  dcache_geometry_pkg::way_t   update_way,
    input  dcache_geometry_pkg::index_t update_index,
    input  logic                       update_write,
    input  logic                       fill,
    input  dcache_geometry_pkg::index_t fill_index,
    input  dcache_geometry_pkg::tag_t   fill_tag,
    input  logic                       fill_dirty,
    output logic                       hit,
    output dcache_geometry_pkg::way_t   hit_way,
    output dcache_geometry_pkg::way_t   victim_way,
    output logic                       victim_dirty,
    output dcache_geometry_pkg::tag_t   victim_tag
);

    logic [dcache_geometry_pkg::WAYS-1:0] valid [dcache_geometry_pkg::SETS];
    logic [dcache_geometry_pkg::WAYS-1:0] dirty [dcache_geometry_pkg::SETS];
    dcache_geometry_pkg::tag_t tags [dcache_geometry_pkg::WAYS][dcache_geometry_pkg::SETS];

    // way to replace next, per set
    logic [dcache_geometry_pkg::SETS-1:0] plru;

    dcache_geometry_pkg::index_t index;
    dcache_geometry_pkg::tag_t tag;
    logic [dcache_geometry_pkg::WAYS-1:0] hit_bits;
    dcache_geometry_pkg::way_t fill_way;

    assign index = dcache_geometry_pkg::index_t'(lookup_addr >> dcache_geometry_pkg::INDEX_LSB);
    assign tag = dcache_geometry_pkg::tag_t'(lookup_addr >> dcache_geometry_pkg::TAG_LSB);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_geometry_pkg::WAYS; w++) begin
            hit_bits[w] = valid[index][w] && (tags[w][index] == tag);
            if (hit_bits[w]) begin
                hit_way = dcache_geometry_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_bits;

    // victim is whatever plru points at
    assign victim_way = plru[index];
    assign victim_dirty = valid[index][victim_way] & dirty[index][victim_way];
    assign victim_tag = tags[victim_way][index];

    // refill lands in the plru way, unchanged while the miss runs
    assign fill_way = plru[fill_index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            plru <= '0;
        end else if (fill) begin
            valid[fill_index][fill_way] <= 1'b1;
            dirty[fill_index][fill_way] <= fill_dirty;
            plru[fill_index] <= ~fill_way;
        end else if (update_hit) begin
            plru[update_index] <= ~update_way;
            if (update_write) begin
                dirty[update_index][update_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][fill_index] <= fill_tag;
        end
    end

endmodule

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

    // every burst moves one full line
    localparam int BURST_LEN = 16;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one enable per byte lane
    typedef logic [3:0] strobe_t;

endpackage

//--- testbench/dcache_properties.sv
`timescale 1ns/10ps

module dcache_properties (
    input logic               clk,
    input logic               resetn,
    input logic               req_valid,
    input logic               addr_ok,
    input logic               data_ok,
    input logic               mem_valid,
    input logic               mem_ready,
    input logic               mem_write,
    input mem_bus_pkg::addr_t mem_addr
);

    // requests accepted but not yet answered
    logic [3:0] outstanding;

    always_ff @(posedge clk) begin
        if (resetn) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(req_valid && addr_ok) - 4'(data_ok);
        end
    end

    // a beat waiting for ready keeps its request
    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) && $stable(mem_addr))
        else $error("memory request changed while waiting for ready");

    assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> outstanding != '0)
        else $error("data_ok without an outstanding request");

    assert property (@(posedge clk) resetn |=> !mem_valid)
        else $error("mem_valid high out of reset");

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;

    localparam int ADDR_OK_LIMIT = 1000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int RANDOM_REQUESTS = 300;
    localparam int LINE_BYTES = mem_bus_pkg::BURST_LEN * 4;

    logic clk = 1'b0;
    logic resetn;
    logic req_valid;
    mem_bus_pkg::addr_t req_addr;
    mem_bus_pkg::strobe_t req_strobe;
    mem_bus_pkg::word_t req_wdata;
    logic mem_ready;
    logic mem_last;
    mem_bus_pkg::word_t mem_rdata;
    logic addr_ok;
    logic data_ok;
    mem_bus_pkg::word_t rdata;
    logic mem_valid;
    logic mem_write;
    mem_bus_pkg::addr_t mem_addr;
    mem_bus_pkg::word_t mem_wdata;

    // what the cpu wrote
    mem_bus_pkg::word_t shadow [mem_bus_pkg::addr_t];
    // what reached memory
    mem_bus_pkg::word_t mem_words [mem_bus_pkg::addr_t];

    mem_bus_pkg::word_t expect_q [$];
    logic is_read_q [$];

    // completed bursts in order
    mem_bus_pkg::addr_t burst_addr_q [$];
    logic burst_write_q [$];

    always #4 clk = ~clk;

    dcache dcache_inst (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .mem_ready  (mem_ready),
        .mem_last   (mem_last),
        .mem_rdata  (mem_rdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    bind dcache dcache_properties dcache_properties_inst (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_write (mem_write),
        .mem_addr  (mem_addr)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic mem_bus_pkg::word_t init_word(input mem_bus_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h2e96_0000;
    endfunction

    function automatic mem_bus_pkg::word_t shadow_word(input mem_bus_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic mem_bus_pkg::word_t memory_word(input mem_bus_pkg::addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return init_word(a);
    endfunction

    // word a request sees after the strobe merge of a write
    function automatic mem_bus_pkg::word_t reference_access(
        input mem_bus_pkg::addr_t   a,
        input mem_bus_pkg::strobe_t s,
        input mem_bus_pkg::word_t   d
    );
        mem_bus_pkg::addr_t wa;
        mem_bus_pkg::word_t w;
        wa = {a[31:2], 2'b00};
        w = shadow_word(wa);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        if (s != '0) begin
            shadow[wa] = w;
        end
        return w;
    endfunction

    task automatic issue_request(
        input mem_bus_pkg::addr_t   a,
        input mem_bus_pkg::strobe_t s,
        input mem_bus_pkg::word_t   d
    );
        int waited;
        waited = 0;
        req_valid = 1'b1;
        req_addr = a;
        req_strobe = s;
        req_wdata = d;
        @(negedge clk);
        while (addr_ok !== 1'b1) begin
            waited++;
            assert (waited < ADDR_OK_LIMIT)
                else stop_on_error("addr_ok stayed low, request never accepted");
            @(negedge clk);
        end
        // accepted on the coming edge
        expect_q.push_back(reference_access(a, s, d));
        is_read_q.push_back(s == '0);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        while (expect_q.size() != 0) begin
            waited++;
            assert (waited < DRAIN_LIMIT)
                else stop_on_error("responses did not arrive in time");
            @(posedge clk);
            #1;
        end
    endtask

    // compare responses in order
    always @(negedge clk) begin
        mem_bus_pkg::word_t expected;
        logic is_read;
        if (resetn === 1'b0 && data_ok === 1'b1) begin
            assert (expect_q.size() != 0)
                else stop_on_error($sformatf("data_ok at %0t without a pending request", $time));
            expected = expect_q.pop_front();
            is_read = is_read_q.pop_front();
            if (is_read) begin
                assert (rdata === expected)
                    else stop_on_error($sformatf("mismatch at %0t: rdata expected %08h got %08h",
                                                 $time, expected, rdata));
            end
        end
    end

    // memory model with random ready stalls
    initial begin
        logic fire;
        logic waiting;
        logic write_s;
        mem_bus_pkg::addr_t addr_s;
        mem_bus_pkg::word_t wdata_s;
        mem_bus_pkg::addr_t base;
        mem_bus_pkg::addr_t beat_addr;
        int beat;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_rdata = '0;
        waiting = 1'b0;
        beat = 0;
        base = '0;
        forever begin
            @(negedge clk);
            if (waiting) begin
                assert (mem_valid === 1'b1 && mem_addr === addr_s && mem_write === write_s)
                    else stop_on_error("memory request changed while waiting for ready");
            end
            fire = (resetn === 1'b0) && (mem_valid === 1'b1) && mem_ready;
            waiting = (resetn === 1'b0) && (mem_valid === 1'b1) && !mem_ready;
            write_s = mem_write;
            addr_s = mem_addr;
            wdata_s = mem_wdata;
            @(posedge clk);
            #1;
            if (fire) begin
                if (beat == 0) begin
                    base = addr_s;
                    assert (addr_s % LINE_BYTES == 0)
                        else stop_on_error($sformatf("burst at %08h is not line aligned", addr_s));
                end
                beat_addr = base + mem_bus_pkg::addr_t'(4 * beat);
                if (write_s) begin
                    assert (wdata_s === shadow_word(beat_addr))
                        else stop_on_error($sformatf(
                            "mismatch at %0t: mem_wdata expected %08h got %08h",
                            $time, shadow_word(beat_addr), wdata_s));
                    mem_words[beat_addr] = wdata_s;
                end
                beat++;
                if (beat == mem_bus_pkg::BURST_LEN) begin
                    burst_addr_q.push_back(base);
                    burst_write_q.push_back(write_s);
                    beat = 0;
                end
            end
            mem_ready = (mem_valid === 1'b1) && ($urandom % 4 != 0);
            mem_last = (beat == mem_bus_pkg::BURST_LEN - 1);
            if (mem_valid === 1'b1 && mem_write === 1'b0) begin
                mem_rdata = memory_word(mem_addr + mem_bus_pkg::addr_t'(4 * beat));
            end else begin
                mem_rdata = '0;
            end
        end
    end

    initial begin
        mem_bus_pkg::addr_t a;
        mem_bus_pkg::addr_t line_a;
        mem_bus_pkg::strobe_t s;
        int first_burst;
        int write_bursts;
        void'($urandom(32'h2e96));
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b0;

        assert (addr_ok === 1'b1) else stop_on_error("addr_ok is not high out of reset");
        assert (data_ok === 1'b0) else stop_on_error("data_ok is not low out of reset");
        assert (mem_valid === 1'b0) else stop_on_error("mem_valid is not low out of reset");

        // cold read gives one refill burst
        first_burst = burst_addr_q.size();
        issue_request(32'h0000_1234, 4'b0000, '0);
        wait_responses();
        assert (burst_addr_q.size() == first_burst + 1)
            else stop_on_error("cold read did not give exactly one burst");
        assert (burst_write_q[first_burst] == 1'b0)
            else stop_on_error("cold read burst was not a read");
        assert (burst_addr_q[first_burst] === 32'h0000_1200)
            else stop_on_error($sformatf("mismatch at %0t: mem_addr expected %08h got %08h",
                                         $time, 32'h0000_1200, burst_addr_q[first_burst]));

        // partial strobes, hits and one write miss
        issue_request(32'h0000_1234, 4'b0011, 32'hdead_beef);
        issue_request(32'h0000_1234, 4'b0000, '0);
        issue_request(32'h0000_1238, 4'b1000, 32'h1122_3344);
        issue_request(32'h0000_1238, 4'b0101, 32'haabb_ccdd);
        issue_request(32'h0000_1238, 4'b0000, '0);
        issue_request(32'h0000_5604, 4'b0110, 32'h0f0f_f0f0);
        issue_request(32'h0000_5604, 4'b0000, '0);
        issue_request(32'h0000_123c, 4'b1111, 32'h7654_3210);
        issue_request(32'h0000_123c, 4'b0000, '0);
        wait_responses();

        // three lines in set 2 evict the first one dirty
        first_burst = burst_addr_q.size();
        issue_request(32'h0000_2080, 4'b1111, 32'ha0a0_0001);
        issue_request(32'h0000_2080, 4'b0000, '0);
        issue_request(32'h0000_30a4, 4'b1100, 32'hb0b0_0002);
        issue_request(32'h0000_30a4, 4'b0000, '0);
        issue_request(32'h0000_4088, 4'b0001, 32'hc0c0_0003);
        issue_request(32'h0000_4088, 4'b0000, '0);
        wait_responses();
        write_bursts = 0;
        line_a = '0;
        for (int i = first_burst; i < burst_addr_q.size(); i++) begin
            if (burst_write_q[i]) begin
                if (write_bursts == 0) begin
                    line_a = burst_addr_q[i];
                end
                write_bursts++;
            end
        end
        assert (write_bursts == 1)
            else stop_on_error($sformatf("expected one writeback, saw %0d", write_bursts));
        assert (line_a === 32'h0000_2080)
            else stop_on_error($sformatf("mismatch at %0t: mem_addr expected %08h got %08h",
                                         $time, 32'h0000_2080, line_a));
        issue_request(32'h0000_2080, 4'b0000, '0);
        issue_request(32'h0000_2084, 4'b0000, '0);
        issue_request(32'h0000_30a4, 4'b0000, '0);
        wait_responses();

        // random traffic over 3 tags x 2 sets
        for (int n = 0; n < RANDOM_REQUESTS; n++) begin
            a = 32'h0001_0000 + (($urandom % 3) << 12) + (($urandom % 2) << 6)
              + (($urandom % 16) << 2);
            s = ($urandom % 2 == 0) ? 4'b0000 : mem_bus_pkg::strobe_t'($urandom % 16);
            issue_request(a, s, $urandom);
            if ($urandom % 4 == 0) begin
                idle_cycles($urandom % 3 + 1);
            end
        end
        wait_responses();
        idle_cycles(4);

        $display(">>> PASS");
        $finish;
    end

endmodule
